// ==== cart_cfg.svh ====
// Shared widths, header offsets and defaults that the cartridge loader RTL and testbench include
`ifndef CART_CFG_SVH
`define CART_CFG_SVH

// ======================================================================
// Host download stream
// ======================================================================
`define CART_DL_ADDR_W 25
`define CART_DL_DATA_W 16

// Stream index that carries cheat codes
`define CART_CODE_INDEX 8'hFF

// ======================================================================
// ROM header layout
// ======================================================================
`define CART_MASK_W 24
`define CART_COPIER_OFS 25'h200

// Internal ROM size fields with the RAM size 2 bytes later
`define CART_LOROM_HDR 25'h7FD6
`define CART_HIROM_HDR 25'hFFD6
`define CART_EXHIROM_HDR 25'h40FFD6

`define CART_DEFAULT_ROM_SIZE 4'hC

// Backup file sectors
`define CART_LBA_W 32
`define CART_SECTOR_SHIFT 9

`endif

// ==== cart_pkg.sv ====
// Cartridge types shared by the header parser, the backup sequencer and the top level
`include "cart_cfg.svh"

package cart_pkg;

	// Auto follows the copier header and the rest force a layout
	typedef enum logic [2:0] {
		hdr_auto    = 3'd0,
		hdr_none    = 3'd1,
		hdr_lorom   = 3'd2,
		hdr_hirom   = 3'd3,
		hdr_exhirom = 3'd4
	} header_mode_e;

	// Video region selection
	typedef enum logic [1:0] {
		region_auto = 2'd0,
		region_ntsc = 2'd1,
		region_pal  = 2'd2
	} region_mode_e;

	// Cartridge description handed to the console core
	typedef struct packed {
		logic [7:0]              rom_type;
		logic [`CART_MASK_W-1:0] rom_mask;
		logic [`CART_MASK_W-1:0] ram_mask;
	} rom_info_t;

endpackage

// ==== host_pkg.sv ====
// Host side types for the download stream, image status, cheat codes and sector requests
`include "cart_cfg.svh"

package host_pkg;

	// One word of the download stream
	typedef struct packed {
		logic                       wr;
		logic [`CART_DL_ADDR_W-1:0] addr;
		logic [`CART_DL_DATA_W-1:0] data;
	} dl_word_t;

	// Backup image as reported by the host
	typedef struct packed {
		logic mounted;
		logic readonly;
		logic nonempty;
	} img_status_t;

	// Valid is the top bit and clocks the code into the list
	typedef struct packed {
		logic        valid;
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	// Sector port request
	typedef struct packed {
		logic [`CART_LBA_W-1:0] lba;
		logic                   rd;
		logic                   wr;
	} sd_req_t;

	typedef enum logic {
		bk_idle     = 1'b0,
		bk_transfer = 1'b1
	} bk_state_e;

endpackage

// ==== download_router.sv ====
// Splits the host download into cartridge and cheat traffic and pulses on cartridge start and end
`timescale 1ns/1ns
`include "cart_cfg.svh"

module download_router (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       dl_active,
	input  logic [7:0] dl_index,
	output logic       cart_dl,
	output logic       code_dl,
	output logic       cart_start,
	output logic       cart_end
);

	logic is_code;
	logic cart_dl_q;

	assign is_code = (dl_index == `CART_CODE_INDEX);
	assign code_dl = dl_active & is_code;
	assign cart_dl = dl_active & ~is_code;

	// Edge pulses land one cycle after the download flag changes
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			cart_dl_q  <= 1'b0;
			cart_start <= 1'b0;
			cart_end   <= 1'b0;
		end else begin
			cart_dl_q  <= cart_dl;
			cart_start <= cart_dl & ~cart_dl_q;
			cart_end   <= ~cart_dl & cart_dl_q;
		end
	end

endmodule

// ==== rom_header_parser.sv ====
// Watches the cartridge download for header fields and derives ROM type, size masks and region
`timescale 1ns/1ns
`include "cart_cfg.svh"

module rom_header_parser
	import cart_pkg::*;
	import host_pkg::*;
(
	input  logic         clk_sys,
	input  logic         reset,
	input  dl_word_t     dl,
	input  logic         cart_dl,
	input  header_mode_e header_mode,
	input  region_mode_e region_mode,
	output rom_info_t    rom_info,
	output logic         pal
);

	localparam logic [`CART_MASK_W-1:0] mask_base = 1024;
	localparam logic [`CART_MASK_W-1:0] mask_one = 1;
	localparam logic [`CART_DL_ADDR_W-1:0] region_addr = 2;
	localparam logic [`CART_DL_ADDR_W-1:0] ram_field_ofs = 2;

	logic [3:0]                 rom_size;
	logic [3:0]                 ram_size;
	logic [7:0]                 rom_type;
	logic                       rom_region;
	logic                       hdr_internal;
	logic [`CART_DL_ADDR_W-1:0] size_addr;
	logic                       pal_sel;

	// Internal header location for the forced layouts
	always_comb begin
		hdr_internal = 1'b1;
		case (header_mode)
			hdr_lorom:   size_addr = `CART_LOROM_HDR + `CART_COPIER_OFS;
			hdr_hirom:   size_addr = `CART_HIROM_HDR + `CART_COPIER_OFS;
			hdr_exhirom: size_addr = `CART_EXHIROM_HDR + `CART_COPIER_OFS;
			default: begin
				size_addr    = '0;
				hdr_internal = 1'b0;
			end
		endcase
	end

	assign pal_sel = (region_mode == region_auto) ? rom_region : (region_mode == region_pal);

	// ======================================================================
	// Header capture
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			rom_size   <= `CART_DEFAULT_ROM_SIZE;
			ram_size   <= 4'h0;
			rom_type   <= 8'h00;
			rom_region <= 1'b0;
			pal        <= 1'b0;
		end else if (cart_dl) begin
			if (dl.wr) begin
				if (dl.addr == '0) begin
					rom_size <= `CART_DEFAULT_ROM_SIZE;
					ram_size <= 4'h0;
					// Copier byte holds RAM size high, ROM size low
					if (header_mode == hdr_auto && dl.data[7:0] != 8'h00)
						{ram_size, rom_size} <= dl.data[7:0];
					case (header_mode)
						hdr_none, hdr_lorom: rom_type <= 8'h00;
						hdr_hirom:           rom_type <= 8'h01;
						hdr_exhirom:         rom_type <= 8'h02;
						default:             rom_type <= dl.data[15:8];
					endcase
				end
				if (dl.addr == region_addr)
					rom_region <= dl.data[8];
				if (hdr_internal) begin
					if (dl.addr == size_addr)
						rom_size <= dl.data[11:8];
					if (dl.addr == size_addr + ram_field_ofs)
						ram_size <= dl.data[3:0];
				end
			end
		end else begin
			pal <= pal_sel;
		end
	end

	// Masks follow the stored sizes directly
	always_comb begin
		rom_info.rom_type = rom_type;
		rom_info.rom_mask = (mask_base << rom_size) - mask_one;
		rom_info.ram_mask = (ram_size != 4'h0) ? (mask_base << ram_size) - mask_one : '0;
	end

endmodule

// ==== cheat_code_assembler.sv ====
// Packs 16-bit cheat words from the download stream into complete codes for the cheat list
`timescale 1ns/1ns

module cheat_code_assembler
	import host_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  dl_word_t    dl,
	input  logic        code_dl,
	input  logic        cart_dl,
	output cheat_code_t cheat,
	output logic        cheat_clear
);

	logic        code_wr;
	logic        valid_q;
	logic        clear_q;
	logic [31:0] flags_q;
	logic [31:0] address_q;
	logic [31:0] compare_q;
	logic [31:0] replace_q;

	assign code_wr = code_dl & dl.wr;

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			valid_q <= 1'b0;
			clear_q <= 1'b0;
		end else begin
			// Replace top word completes a code
			valid_q <= code_wr && dl.addr[3:0] == 4'd14;
			clear_q <= code_wr && dl.addr == '0;
		end
	end

	// Bottom word at the lower offset, top word 2 bytes above
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (dl.addr[3:0])
				4'd0:  flags_q[15:0]    <= dl.data;
				4'd2:  flags_q[31:16]   <= dl.data;
				4'd4:  address_q[15:0]  <= dl.data;
				4'd6:  address_q[31:16] <= dl.data;
				4'd8:  compare_q[15:0]  <= dl.data;
				4'd10: compare_q[31:16] <= dl.data;
				4'd12: replace_q[15:0]  <= dl.data;
				4'd14: replace_q[31:16] <= dl.data;
				default: ;
			endcase
		end
	end

	assign cheat = '{valid: valid_q, flags: flags_q, address: address_q,
		compare: compare_q, replace: replace_q};

	// List is also held clear for a whole cartridge load
	assign cheat_clear = clear_q | cart_dl;

endmodule

// ==== backup_sequencer.sv ====
// Moves the battery backup file over the sector port for load after download, save and autosave
`timescale 1ns/1ns
`include "cart_cfg.svh"

module backup_sequencer
	import host_pkg::*;
(
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    cart_dl,
	input  logic                    cart_start,
	input  logic                    cart_end,
	input  logic [`CART_MASK_W-1:0] ram_mask,
	input  img_status_t             img,
	input  logic                    menu_open,
	input  logic                    autosave_en,
	input  logic                    bk_load_req,
	input  logic                    bk_save_req,
	input  logic                    bsram_write,
	input  logic                    sd_ack,
	output sd_req_t                 sd_req,
	output logic                    bk_busy,
	output logic                    bk_loading,
	output logic                    bk_enabled,
	output logic                    bk_pending
);

	localparam logic [`CART_LBA_W-1:0] lba_one = 1;

	bk_state_e              state;
	logic                   load_q;
	logic                   save_q;
	logic                   auto_q;
	logic                   ack_q;
	logic                   load_rise;
	logic                   save_rise;
	logic                   auto_rise;
	logic                   ack_rise;
	logic                   ack_fall;
	logic                   start_rd;
	logic                   start_wr;
	logic [`CART_LBA_W-1:0] last_lba;

	assign load_rise = bk_load_req & bk_enabled & ~load_q;
	assign save_rise = bk_save_req & bk_enabled & ~save_q;
	assign auto_rise = autosave_en & bk_pending & menu_open & ~auto_q;
	assign ack_rise  = sd_ack & ~ack_q;
	assign ack_fall  = ~sd_ack & ack_q;

	// Reload after a download has priority over the user requests
	assign start_rd = (cart_end & img.nonempty & bk_enabled) | load_rise;
	assign start_wr = ~start_rd & (save_rise | auto_rise);

	// Last sector index of the backup RAM
	assign last_lba = {{(`CART_LBA_W-`CART_MASK_W){1'b0}}, ram_mask >> `CART_SECTOR_SHIFT};
	assign bk_busy  = (state == bk_transfer);

	// ======================================================================
	// Enable and pending flags
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			bk_enabled <= 1'b0;
			bk_pending <= 1'b0;
			load_q     <= 1'b0;
			save_q     <= 1'b0;
			auto_q     <= 1'b0;
			ack_q      <= 1'b0;
		end else begin
			load_q <= bk_load_req & bk_enabled;
			save_q <= bk_save_req & bk_enabled;
			auto_q <= bk_pending & menu_open;
			ack_q  <= sd_ack;
			if (cart_start)
				bk_enabled <= 1'b0;
			// Save image is mounted by the time the download runs
			if (cart_dl && img.mounted && !img.readonly)
				bk_enabled <= |ram_mask;
			if (bk_enabled && !menu_open && bsram_write)
				bk_pending <= 1'b1;
			else if (bk_busy)
				bk_pending <= 1'b0;
		end
	end

	// ======================================================================
	// Sector FSM
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			state      <= bk_idle;
			sd_req     <= '0;
			bk_loading <= 1'b0;
		end else begin
			if (ack_rise) begin
				sd_req.rd <= 1'b0;
				sd_req.wr <= 1'b0;
			end
			case (state)
				bk_idle: begin
					if (start_rd || start_wr) begin
						state      <= bk_transfer;
						bk_loading <= start_rd;
						sd_req.lba <= '0;
						sd_req.rd  <= start_rd;
						sd_req.wr  <= start_wr;
					end
				end
				bk_transfer: begin
					if (ack_fall) begin
						if (sd_req.lba >= last_lba) begin
							state      <= bk_idle;
							bk_loading <= 1'b0;
						end else begin
							// Next sector, same direction
							sd_req.lba <= sd_req.lba + lba_one;
							sd_req.rd  <= bk_loading;
							sd_req.wr  <= ~bk_loading;
						end
					end
				end
				default: state <= bk_idle;
			endcase
		end
	end

endmodule

// ==== cart_loader_top.sv ====
// Top level of the cartridge loader that wires the router, header parser, cheat assembler and backup
`timescale 1ns/1ns

module cart_loader_top
	import cart_pkg::*;
	import host_pkg::*;
(
	input  logic         clk_sys,
	input  logic         reset,
	input  dl_word_t     dl,
	input  logic         dl_active,
	input  logic [7:0]   dl_index,
	input  header_mode_e header_mode,
	input  region_mode_e region_mode,
	input  img_status_t  img,
	input  logic         menu_open,
	input  logic         autosave_en,
	input  logic         bk_load_req,
	input  logic         bk_save_req,
	input  logic         bsram_write,
	input  logic         sd_ack,
	output rom_info_t    rom_info,
	output logic         pal,
	output cheat_code_t  cheat,
	output logic         cheat_clear,
	output sd_req_t      sd_req,
	output logic         bk_busy,
	output logic         bk_loading,
	output logic         bk_enabled,
	output logic         bk_pending
);

	logic cart_dl;
	logic code_dl;
	logic cart_start;
	logic cart_end;

	download_router u_router (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.dl_active  (dl_active),
		.dl_index   (dl_index),
		.cart_dl    (cart_dl),
		.code_dl    (code_dl),
		.cart_start (cart_start),
		.cart_end   (cart_end)
	);

	rom_header_parser u_header (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl          (dl),
		.cart_dl     (cart_dl),
		.header_mode (header_mode),
		.region_mode (region_mode),
		.rom_info    (rom_info),
		.pal         (pal)
	);

	cheat_code_assembler u_cheat (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl          (dl),
		.code_dl     (code_dl),
		.cart_dl     (cart_dl),
		.cheat       (cheat),
		.cheat_clear (cheat_clear)
	);

	// Backup size comes from the parsed header
	backup_sequencer u_backup (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.cart_dl     (cart_dl),
		.cart_start  (cart_start),
		.cart_end    (cart_end),
		.ram_mask    (rom_info.ram_mask),
		.img         (img),
		.menu_open   (menu_open),
		.autosave_en (autosave_en),
		.bk_load_req (bk_load_req),
		.bk_save_req (bk_save_req),
		.bsram_write (bsram_write),
		.sd_ack      (sd_ack),
		.sd_req      (sd_req),
		.bk_busy     (bk_busy),
		.bk_loading  (bk_loading),
		.bk_enabled  (bk_enabled),
		.bk_pending  (bk_pending)
	);

endmodule

// ==== tb_cart_loader.sv ====
// Testbench for the cartridge loader that replays cart_trace.txt against a sector device model
`timescale 1ns/1ns
`include "cart_cfg.svh"

module tb_cart_loader
	import cart_pkg::*;
	import host_pkg::*;
;

	logic         clk_sys;
	logic         reset;
	dl_word_t     dl;
	logic         dl_active;
	logic [7:0]   dl_index;
	header_mode_e header_mode;
	region_mode_e region_mode;
	img_status_t  img;
	logic         menu_open;
	logic         autosave_en;
	logic         bk_load_req;
	logic         bk_save_req;
	logic         bsram_write;
	logic         sd_ack;
	rom_info_t    rom_info;
	logic         pal;
	cheat_code_t  cheat;
	logic         cheat_clear;
	sd_req_t      sd_req;
	logic         bk_busy;
	logic         bk_loading;
	logic         bk_enabled;
	logic         bk_pending;

	// Trace command and its fields
	logic [7:0]  cmd;
	logic [31:0] fld [0:5];
	string       f_name;
	logic [63:0] f_val;

	// Sector requests seen by the device model
	logic [31:0] rec_lba [$];
	logic        rec_rd [$];
	logic        rec_wr [$];
	logic        rec_loading [$];

	cheat_code_t cap_code;
	int          cheat_count = 0;
	logic        clear_seen = 1'b0;
	int          wd_limit = 0;
	logic        wd_armed = 1'b0;

	cart_loader_top u_dut (.*);

	always #4 clk_sys = ~clk_sys;

	// ======================================================================
	// Reporting
	// ======================================================================
	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected) begin
			$display("error %s expected %h actual %h", name, expected, actual);
			$display("Result: FAILED");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1, "run aborted");
	endtask

	// ======================================================================
	// Trace reading
	// ======================================================================
	task automatic read_command(input int fd, output bit ok);
		int code;
		int c;
		ok = 1'b0;
		code = $fscanf(fd, " %c", cmd);
		if (code != 1)
			return;
		case (cmd)
			"#": begin
				c = 0;
				while (c != 10 && c != -1)
					c = $fgetc(fd);
			end
			"W": code = $fscanf(fd, " %h %h %h", fld[0], fld[1], fld[2]);
			"S": code = $fscanf(fd, " %h %h %h %h %h %h", fld[0], fld[1], fld[2],
				fld[3], fld[4], fld[5]);
			"X": code = $fscanf(fd, " %s %h", f_name, f_val);
			"L": code = $fscanf(fd, " %h %h", fld[0], fld[1]);
			"V", "A": code = $fscanf(fd, " %h", fld[0]);
			"E": ;
			default: abort_run("trace holds an unknown command letter");
		endcase
		ok = 1'b1;
	endtask

	// ======================================================================
	// Stimulus
	// ======================================================================
	task automatic end_download();
		if (dl_active) begin
			@(negedge clk_sys);
			dl_active = 1'b0;
			repeat (4) @(negedge clk_sys);
		end
	endtask

	task automatic drive_word(input logic [7:0] idx, input logic [24:0] addr,
		input logic [15:0] data);
		if (dl_active && dl_index != idx)
			end_download();
		@(negedge clk_sys);
		dl_active = 1'b1;
		dl_index  = idx;
		dl.wr     = 1'b1;
		dl.addr   = addr;
		dl.data   = data;
		@(negedge clk_sys);
		dl.wr = 1'b0;
	endtask

	task automatic check_signal(input string name, input logic [63:0] value);
		case (name)
			"rom_type":    check_value(name, value, 64'(rom_info.rom_type));
			"rom_mask":    check_value(name, value, 64'(rom_info.rom_mask));
			"ram_mask":    check_value(name, value, 64'(rom_info.ram_mask));
			"pal":         check_value(name, value, 64'(pal));
			"clear_seen":  check_value(name, value, 64'(clear_seen));
			"cheat_count": check_value(name, value, 64'(cheat_count));
			"flags":       check_value(name, value, 64'(cap_code.flags));
			"address":     check_value(name, value, 64'(cap_code.address));
			"compare":     check_value(name, value, 64'(cap_code.compare));
			"replace":     check_value(name, value, 64'(cap_code.replace));
			"bk_enabled":  check_value(name, value, 64'(bk_enabled));
			"bk_pending":  check_value(name, value, 64'(bk_pending));
			default: abort_run({"trace names an unknown signal: ", name});
		endcase
	endtask

	// Load, save or autosave, then compare the recorded sector list
	task automatic sector_step(input bit load, input bit save, input bit menu,
		input bit is_wr, input int n);
		@(negedge clk_sys);
		bk_load_req = load;
		bk_save_req = save;
		if (menu)
			menu_open = 1'b1;
		repeat (2) @(negedge clk_sys);
		bk_load_req = 1'b0;
		bk_save_req = 1'b0;
		if (n == 0) begin
			repeat (32) @(negedge clk_sys);
		end else begin
			while (rec_lba.size() < n)
				@(negedge clk_sys);
			while (bk_busy)
				@(negedge clk_sys);
		end
		repeat (4) @(negedge clk_sys);
		check_value("sector_count", 64'(n), 64'(rec_lba.size()));
		for (int i = 0; i < n; i++) begin
			check_value("sd_req.lba", 64'(i), 64'(rec_lba[i]));
			check_value("sd_req.rd", 64'(!is_wr), 64'(rec_rd[i]));
			check_value("sd_req.wr", 64'(is_wr), 64'(rec_wr[i]));
			check_value("bk_loading", 64'(!is_wr), 64'(rec_loading[i]));
		end
		check_value("bk_busy", 64'(0), 64'(bk_busy));
		check_value("bk_loading", 64'(0), 64'(bk_loading));
		menu_open = 1'b0;
		rec_lba.delete();
		rec_rd.delete();
		rec_wr.delete();
		rec_loading.delete();
	endtask

	task automatic run_command();
		if (cmd != "W" && cmd != "#")
			end_download();
		case (cmd)
			"W": drive_word(fld[0][7:0], fld[1][24:0], fld[2][15:0]);
			"S": begin
				@(negedge clk_sys);
				header_mode = header_mode_e'(fld[0][2:0]);
				region_mode = region_mode_e'(fld[1][1:0]);
				img         = fld[2][2:0];
				menu_open   = fld[3][0];
				autosave_en = fld[4][0];
				if (fld[5][0]) begin
					@(negedge clk_sys);
					bsram_write = 1'b1;
					@(negedge clk_sys);
					bsram_write = 1'b0;
				end
			end
			"X": check_signal(f_name, f_val);
			"L": sector_step(fld[0][0], 1'b0, 1'b0, 1'b0, int'(fld[1]));
			"V": sector_step(1'b0, 1'b1, 1'b0, 1'b1, int'(fld[0]));
			"A": sector_step(1'b0, 1'b0, 1'b1, 1'b1, int'(fld[0]));
			default: ;
		endcase
	endtask

	// ======================================================================
	// Sector device and monitors
	// ======================================================================
	initial begin
		int delay;
		int hold;
		void'($urandom(32'h7972));
		sd_ack = 1'b0;
		wait (reset === 1'b1);
		forever begin
			@(negedge clk_sys);
			if (sd_req.rd || sd_req.wr) begin
				rec_lba.push_back(sd_req.lba);
				rec_rd.push_back(sd_req.rd);
				rec_wr.push_back(sd_req.wr);
				rec_loading.push_back(bk_loading);
				delay = 1 + int'($urandom % 6);
				repeat (delay) @(negedge clk_sys);
				sd_ack = 1'b1;
				hold = 2 + int'($urandom % 3);
				repeat (hold) @(negedge clk_sys);
				while (sd_req.rd || sd_req.wr)
					@(negedge clk_sys);
				sd_ack = 1'b0;
			end
		end
	end

	// Valid pulses are counted, not timed
	always @(negedge clk_sys) begin
		if (cheat.valid === 1'b1) begin
			cheat_count = cheat_count + 1;
			cap_code = cheat;
		end
		if (cheat_clear && dl_active && dl_index != `CART_CODE_INDEX)
			clear_seen = 1'b1;
	end

	initial begin
		wait (wd_armed);
		repeat (wd_limit) @(posedge clk_sys);
		abort_run($sformatf("Timeout: trace did not finish within %0d cycles", wd_limit));
	end

	// ======================================================================
	// Main sequence
	// ======================================================================
	initial begin
		int  fd;
		int  lines;
		int  sectors;
		bit  ok;
		bit  done;
		clk_sys     = 1'b0;
		reset       = 1'b0;
		dl          = '0;
		dl_active   = 1'b0;
		dl_index    = 8'h00;
		header_mode = hdr_auto;
		region_mode = region_auto;
		img         = '0;
		menu_open   = 1'b0;
		autosave_en = 1'b0;
		bk_load_req = 1'b0;
		bk_save_req = 1'b0;
		bsram_write = 1'b0;

		// First pass sizes the watchdog
		fd = $fopen("cart_trace.txt", "r");
		if (fd == 0)
			abort_run("cannot open the trace file cart_trace.txt");
		lines = 0;
		sectors = 0;
		done = 1'b0;
		while (!done) begin
			read_command(fd, ok);
			if (!ok || cmd == "E") begin
				done = 1'b1;
			end else if (cmd != "#") begin
				lines = lines + 1;
				if (cmd == "L")
					sectors = sectors + int'(fld[1]);
				else if (cmd == "V" || cmd == "A")
					sectors = sectors + int'(fld[0]);
			end
		end
		$fclose(fd);
		wd_limit = 16 + lines * 200 + sectors * 64;
		wd_armed = 1'b1;

		repeat (16) @(negedge clk_sys);
		reset = 1'b1;

		fd = $fopen("cart_trace.txt", "r");
		done = 1'b0;
		while (!done) begin
			read_command(fd, ok);
			if (!ok || cmd == "E")
				done = 1'b1;
			else
				run_command();
		end
		end_download();
		$fclose(fd);
		$display("Result: PASSED");
		$finish;
	end

endmodule

// ==== cart_trace.txt ====
# Columns in hex: W index addr data | S hdr_mode region img menu autosave bsram_pulse
# X signal expected | L pulse sectors | V sectors | A sectors | E end of trace
# Auto header from the copier word, region bit set
S 0 0 0 0 0 0
W 00 000000 231A
W 00 000002 0100
W 00 000004 0000
X rom_type 23
X rom_mask 0FFFFF
X ram_mask 7FF
X pal 1
X clear_seen 1
X bk_enabled 0
# Forced hirom layout and forced pal region
S 3 2 0 0 0 0
W 00 000000 231A
W 00 000002 0000
W 00 0101D6 0B00
W 00 0101D8 0003
X rom_type 01
X rom_mask 1FFFFF
X ram_mask 1FFF
X pal 1
# One complete cheat code
S 0 0 0 0 0 0
W FF 000000 5678
W FF 000002 1234
W FF 000004 BEEF
W FF 000006 DEAD
W FF 000008 0011
W FF 00000A 2233
W FF 00000C 4455
W FF 00000E 6677
X cheat_count 1
X flags 12345678
X address DEADBEEF
X compare 22330011
X replace 66774455
# Download with a writable image, automatic load of 4 sectors
S 0 0 5 0 0 0
W 00 000000 231A
W 00 000002 0000
L 0 4
X bk_enabled 1
X pal 0
# Save, then autosave when the menu opens
V 4
S 0 0 5 0 1 1
X bk_pending 1
A 4
X bk_pending 0
# No backup RAM in the header
S 0 0 5 0 0 0
W 00 000000 000A
W 00 000002 0000
X ram_mask 0
X bk_enabled 0
L 1 0
E

// ==== list.f ====
+incdir+.
cart_pkg.sv
host_pkg.sv
download_router.sv
rom_header_parser.sv
cheat_code_assembler.sv
backup_sequencer.sv
cart_loader_top.sv
tb_cart_loader.sv

// ==== Makefile ====
TOOL  = verilator
FLAGS = --binary --timing -j 0
TOP   = tb_cart_loader
FLIST = list.f
BUILD = obj_dir
LOG   = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FLIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
